// ==== compile.f ====
rtl/cpu_params_pkg.sv
rtl/uop_pkg.sv
rtl/intm_rs.sv
rtl/intm_prf.sv
rtl/fu_mul.sv
rtl/fu_div.sv
rtl/cdb_arbiter.sv
rtl/intm_exec.sv
tb/intm_exec_tb.sv

// ==== rtl/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter
    import uop_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  cdb_t mul_result,
    output logic mul_grant,
    input  cdb_t div_result,
    output logic div_grant,
    output cdb_t cdb
);

    // who won the last grant, cleared so the multiplier goes first
    logic last_mul_q;

    assign mul_grant = mul_result.valid && (!div_result.valid || !last_mul_q);
    assign div_grant = div_result.valid && !mul_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul_q <= 1'b0;
        end else if (mul_grant || div_grant) begin
            last_mul_q <= mul_grant;
        end
    end

    always_comb begin
        cdb       = mul_grant ? mul_result : div_result;
        cdb.valid = mul_grant || div_grant;
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_params_pkg.sv ====
`default_nettype none

package cpu_params_pkg;

    // ----------------------------
    // datapath and register widths
    // ----------------------------

    // one integer register
    localparam int XLEN = 32;

    // 64 physical registers behind the rename map
    localparam int PHY_REG_W = 6;

    // x0..x31
    localparam int ARCH_REG_W = 5;

    // reorder buffer tag
    localparam int ROB_ID_W = 5;

    // ----------------------------
    // vector types
    // ----------------------------

    typedef logic [XLEN-1:0] word_t;

    typedef logic [PHY_REG_W-1:0] phy_reg_t;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    typedef logic [ROB_ID_W-1:0] rob_id_t;

endpackage

`default_nettype wire

// ==== rtl/fu_div.sv ====
`default_nettype none

module fu_div
    import cpu_params_pkg::*;
    import uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  fu_req_t req,
    input  logic    valid,
    output logic    ready,
    input  logic    grant,
    output cdb_t    result
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [2:0] {IDLE, LOAD, ITER, FIX, DONE} div_state_t;

    div_state_t       state_q;
    fu_req_t          req_q;
    word_t            dvs_q;
    word_t            rem_q;
    word_t            quo_q;
    word_t            res_q;
    logic [CNT_W-1:0] cnt_q;

    logic             is_signed;
    logic             a_neg;
    logic             b_neg;
    logic [XLEN:0]    rem_sh;
    logic [XLEN:0]    diff;
    word_t            quo_fix;
    word_t            rem_fix;

    assign is_signed = req_q.fu_opcode inside {DIV, REM};
    assign a_neg     = is_signed && req_q.rs1_value[XLEN-1];
    assign b_neg     = is_signed && req_q.rs2_value[XLEN-1];

    // one restoring step, quotient bits shift in from the right
    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    // MIN / -1 already lands on MIN rem 0 through the magnitudes
    always_comb begin
        quo_fix = (a_neg ^ b_neg) ? -quo_q : quo_q;
        rem_fix = a_neg ? -rem_q : rem_q;
        if (req_q.rs2_value == '0) begin
            quo_fix = '1;
            rem_fix = req_q.rs1_value;
        end
    end

    // ----------------------------
    // FSM
    // ----------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (valid) begin
                        state_q <= LOAD;
                    end
                end
                LOAD: state_q <= ITER;
                ITER: begin
                    if (cnt_q == CNT_W'(XLEN - 1)) begin
                        state_q <= FIX;
                    end
                end
                FIX:  state_q <= DONE;
                DONE: begin
                    if (grant) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (valid) begin
                    req_q <= req;
                end
            end
            LOAD: begin
                quo_q <= a_neg ? -req_q.rs1_value : req_q.rs1_value;
                dvs_q <= b_neg ? -req_q.rs2_value : req_q.rs2_value;
                rem_q <= '0;
                cnt_q <= '0;
            end
            ITER: begin
                cnt_q <= cnt_q + 1'b1;
                if (!diff[XLEN]) begin
                    rem_q <= diff[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= rem_sh[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end
            FIX: begin
                res_q <= (req_q.fu_opcode inside {DIV, DIVU}) ? quo_fix : rem_fix;
            end
            default: ;
        endcase
    end

    assign ready = (state_q == IDLE);

    always_comb begin
        result.valid   = (state_q == DONE);
        result.rob_id  = req_q.rob_id;
        result.rd_phy  = req_q.rd_phy;
        result.rd_arch = req_q.rd_arch;
        result.value   = res_q;
    end

endmodule

`default_nettype wire

// ==== rtl/fu_mul.sv ====
`default_nettype none

module fu_mul
    import cpu_params_pkg::*;
    import uop_pkg::*;
#(
    parameter int MUL_STAGES = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  fu_req_t req,
    input  logic    valid,
    output logic    ready,
    input  logic    grant,
    output cdb_t    result
);

    typedef struct packed {
        rob_id_t   rob_id;
        phy_reg_t  rd_phy;
        arch_reg_t rd_arch;
        md_op_t    op;
    } mul_tag_t;

    // stage 0 holds the extended operands, product from stage 1 on
    logic                 vld_q  [MUL_STAGES];
    mul_tag_t             tag_q  [MUL_STAGES];
    logic signed [XLEN:0] a_q;
    logic signed [XLEN:0] b_q;
    logic [2*XLEN-1:0]    prod_q [1:MUL_STAGES-1];

    logic                 a_signed;
    logic                 b_signed;
    logic                 advance;

    assign a_signed = req.fu_opcode inside {MULH, MULHSU};
    assign b_signed = (req.fu_opcode == MULH);

    // whole pipe freezes behind an ungranted result
    assign advance = !(vld_q[MUL_STAGES-1] && !grant);
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < MUL_STAGES; k++) begin
                vld_q[k] <= 1'b0;
            end
        end else if (advance) begin
            vld_q[0] <= valid;
            for (int k = 1; k < MUL_STAGES; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_q[0]  <= '{req.rob_id, req.rd_phy, req.rd_arch, req.fu_opcode};
            a_q       <= {a_signed && req.rs1_value[XLEN-1], req.rs1_value};
            b_q       <= {b_signed && req.rs2_value[XLEN-1], req.rs2_value};
            prod_q[1] <= a_q * b_q;
            for (int k = 1; k < MUL_STAGES; k++) begin
                tag_q[k] <= tag_q[k-1];
            end
            for (int k = 2; k < MUL_STAGES; k++) begin
                prod_q[k] <= prod_q[k-1];
            end
        end
    end

    always_comb begin
        result.valid   = vld_q[MUL_STAGES-1];
        result.rob_id  = tag_q[MUL_STAGES-1].rob_id;
        result.rd_phy  = tag_q[MUL_STAGES-1].rd_phy;
        result.rd_arch = tag_q[MUL_STAGES-1].rd_arch;
        // MUL wants the low word, the MULH forms the high word
        result.value   = (tag_q[MUL_STAGES-1].op == MUL) ? prod_q[MUL_STAGES-1][XLEN-1:0]
                                                         : prod_q[MUL_STAGES-1][2*XLEN-1:XLEN];
    end

endmodule

`default_nettype wire

// ==== rtl/intm_exec.sv ====
`default_nettype none

module intm_exec
    import cpu_params_pkg::*;
    import uop_pkg::*;
#(
    parameter int ID_WIDTH   = 2,
    parameter int RS_DEPTH   = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ID_WIDTH-1:0] ds_valid,
    input  uop_t [ID_WIDTH-1:0] ds_uop,
    output logic                ds_ready,
    input  cdb_t                ext_cdb,
    output cdb_t                cdb
);

    // ----------------------------
    // issue path
    // ----------------------------
    phy_reg_t rs1_phy;
    phy_reg_t rs2_phy;
    word_t    rs1_value;
    word_t    rs2_value;
    fu_req_t  fu_req;
    logic     mul_valid;
    logic     mul_ready;
    logic     div_valid;
    logic     div_ready;

    // unit results waiting for the bus
    cdb_t     mul_result;
    cdb_t     div_result;
    logic     mul_grant;
    logic     div_grant;

    intm_rs #(
        .ID_WIDTH (ID_WIDTH),
        .RS_DEPTH (RS_DEPTH)
    ) intm_rs_i (
        .clk       (clk),
        .rst       (rst),
        .ds_valid  (ds_valid),
        .ds_uop    (ds_uop),
        .ds_ready  (ds_ready),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .fu_req    (fu_req),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .div_valid (div_valid),
        .div_ready (div_ready),
        .local_cdb (cdb),
        .ext_cdb   (ext_cdb)
    );

    intm_prf intm_prf_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .local_cdb (cdb),
        .ext_cdb   (ext_cdb)
    );

    fu_mul #(
        .MUL_STAGES (MUL_STAGES)
    ) fu_mul_i (
        .clk    (clk),
        .rst    (rst),
        .req    (fu_req),
        .valid  (mul_valid),
        .ready  (mul_ready),
        .grant  (mul_grant),
        .result (mul_result)
    );

    fu_div fu_div_i (
        .clk    (clk),
        .rst    (rst),
        .req    (fu_req),
        .valid  (div_valid),
        .ready  (div_ready),
        .grant  (div_grant),
        .result (div_result)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .mul_result (mul_result),
        .mul_grant  (mul_grant),
        .div_result (div_result),
        .div_grant  (div_grant),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

// ==== rtl/intm_prf.sv ====
`default_nettype none

module intm_prf
    import cpu_params_pkg::*;
    import uop_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  phy_reg_t rs1_phy,
    input  phy_reg_t rs2_phy,
    output word_t    rs1_value,
    output word_t    rs2_value,
    input  cdb_t     local_cdb,
    input  cdb_t     ext_cdb
);

    localparam int NUM_REGS = 2 ** PHY_REG_W;

    word_t regs [NUM_REGS];

    // same-cycle bypass, local bus has priority like the write below
    function automatic word_t read_port(phy_reg_t phy, word_t stored, cdb_t lcl, cdb_t ext);
        if (phy == '0) begin
            return '0;
        end
        if (lcl.valid && lcl.rd_phy == phy) begin
            return lcl.value;
        end
        if (ext.valid && ext.rd_phy == phy) begin
            return ext.value;
        end
        return stored;
    endfunction

    assign rs1_value = read_port(rs1_phy, regs[rs1_phy], local_cdb, ext_cdb);
    assign rs2_value = read_port(rs2_phy, regs[rs2_phy], local_cdb, ext_cdb);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ext_cdb.valid && ext_cdb.rd_phy != '0) begin
                regs[ext_cdb.rd_phy] <= ext_cdb.value;
            end
            if (local_cdb.valid && local_cdb.rd_phy != '0) begin
                regs[local_cdb.rd_phy] <= local_cdb.value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/intm_rs.sv ====
`default_nettype none

module intm_rs
    import cpu_params_pkg::*;
    import uop_pkg::*;
#(
    parameter int ID_WIDTH = 2,
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ID_WIDTH-1:0] ds_valid,
    input  uop_t [ID_WIDTH-1:0] ds_uop,
    output logic                ds_ready,
    output phy_reg_t            rs1_phy,
    output phy_reg_t            rs2_phy,
    input  word_t               rs1_value,
    input  word_t               rs2_value,
    output fu_req_t             fu_req,
    output logic                mul_valid,
    input  logic                mul_ready,
    output logic                div_valid,
    input  logic                div_ready,
    input  cdb_t                local_cdb,
    input  cdb_t                ext_cdb
);

    localparam int IDX_W  = $clog2(RS_DEPTH);
    localparam int LANE_W = (ID_WIDTH > 1) ? $clog2(ID_WIDTH) : 1;

    // slot 0 is the oldest, top_q counts occupied slots
    uop_t                rs_q [RS_DEPTH];
    uop_t                rs_d [RS_DEPTH];
    logic [IDX_W:0]      top_q;
    logic [IDX_W:0]      top_d;

    logic [RS_DEPTH-1:0] is_div;
    logic [RS_DEPTH-1:0] req;
    logic                issue_en;
    logic [IDX_W-1:0]    issue_idx;
    logic                pop;

    rs_update_sel_t      update_sel [RS_DEPTH];
    logic [LANE_W-1:0]   push_lane  [RS_DEPTH];

    function automatic logic hit(cdb_t bus, phy_reg_t phy);
        return bus.valid && (bus.rd_phy == phy);
    endfunction

    // mark sources produced by either bus this cycle
    function automatic uop_t wake(uop_t u, cdb_t a, cdb_t b);
        uop_t w;
        w = u;
        if (hit(a, u.rs1_phy) || hit(b, u.rs1_phy)) begin
            w.rs1_valid = 1'b1;
        end
        if (hit(a, u.rs2_phy) || hit(b, u.rs2_phy)) begin
            w.rs2_valid = 1'b1;
        end
        return w;
    endfunction

    // ----------------------------
    // issue select
    // ----------------------------

    always_comb begin
        uop_t woken;
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            woken     = wake(rs_q[i], local_cdb, ext_cdb);
            is_div[i] = rs_q[i].fu_opcode inside {DIV, DIVU, REM, REMU};
            req[i]    = (i < int'(top_q)) && woken.rs1_valid && woken.rs2_valid
                        && (is_div[i] ? div_ready : mul_ready);
        end
        // lowest index wins
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign mul_valid = issue_en && !is_div[issue_idx];
    assign div_valid = issue_en && is_div[issue_idx];
    assign pop       = (mul_valid && mul_ready) || (div_valid && div_ready);

    assign rs1_phy = rs_q[issue_idx].rs1_phy;
    assign rs2_phy = rs_q[issue_idx].rs2_phy;

    always_comb begin
        fu_req.rob_id    = rs_q[issue_idx].rob_id;
        fu_req.rd_phy    = rs_q[issue_idx].rd_phy;
        fu_req.rd_arch   = rs_q[issue_idx].rd_arch;
        fu_req.fu_opcode = rs_q[issue_idx].fu_opcode;
        fu_req.rs1_value = rs1_value;
        fu_req.rs2_value = rs2_value;
    end

    // all lanes or none
    assign ds_ready = (RS_DEPTH - int'(top_q)) >= ID_WIDTH;

    // ----------------------------
    // compress and push
    // ----------------------------

    always_comb begin
        logic [IDX_W:0] slot;
        slot = top_q - (IDX_W + 1)'(pop);
        for (int i = 0; i < RS_DEPTH; i++) begin
            update_sel[i] = (pop && i >= int'(issue_idx)) ? PREV : SELF;
            push_lane[i]  = '0;
        end
        // accepted lanes pack in above the shifted entries
        for (int j = 0; j < ID_WIDTH; j++) begin
            if (ds_valid[j] && ds_ready) begin
                update_sel[IDX_W'(slot)] = PUSH_IN;
                push_lane[IDX_W'(slot)]  = LANE_W'(j);
                slot = slot + 1'b1;
            end
        end
        top_d = slot;
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            case (update_sel[i])
                PREV: begin
                    rs_d[i] = rs_q[(i < RS_DEPTH - 1) ? i + 1 : i];
                end
                PUSH_IN: begin
                    rs_d[i] = ds_uop[push_lane[i]];
                end
                default: begin
                    rs_d[i] = rs_q[i];
                end
            endcase
            // snoop after the move so shifting entries keep wakeups
            rs_d[i] = wake(rs_d[i], local_cdb, ext_cdb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_q <= '0;
        end else begin
            top_q <= top_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs_q[i] <= rs_d[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uop_pkg.sv ====
`default_nettype none

package uop_pkg;

    import cpu_params_pkg::*;

    // ----------------------------
    // M-extension opcodes
    // ----------------------------

    // multiplies in the low half, divides in the high half
    typedef enum logic [2:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU
    } md_op_t;

    // ----------------------------
    // payloads
    // ----------------------------

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        rob_id_t   rob_id;
        phy_reg_t  rd_phy;
        arch_reg_t rd_arch;
        phy_reg_t  rs1_phy;
        logic      rs1_valid;
        phy_reg_t  rs2_phy;
        logic      rs2_valid;
        md_op_t    fu_opcode;
    } uop_t;

    // issued operation, operands already read
    typedef struct packed {
        rob_id_t   rob_id;
        phy_reg_t  rd_phy;
        arch_reg_t rd_arch;
        md_op_t    fu_opcode;
        word_t     rs1_value;
        word_t     rs2_value;
    } fu_req_t;

    // one result broadcast
    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        phy_reg_t  rd_phy;
        arch_reg_t rd_arch;
        word_t     value;
    } cdb_t;

    // next content of a station slot
    typedef enum logic [1:0] {
        SELF,
        PREV,
        PUSH_IN
    } rs_update_sel_t;

endpackage

`default_nettype wire

// ==== tb/intm_exec_tb.sv ====
`default_nettype none

module intm_exec_tb
    import cpu_params_pkg::*;
    import uop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ID_WIDTH   = 2;
    localparam int RS_DEPTH   = 8;
    localparam int MUL_STAGES = 3;
    localparam int DIR_ROWS   = 22;
    localparam int BURST_ROWS = 16;
    localparam int N_ROWS     = DIR_ROWS + BURST_ROWS;
    localparam int MAX_CYCLES = N_ROWS * (XLEN + 2 + MUL_STAGES + 4) + 200;
    localparam int N_ROB      = 2 ** ROB_ID_W;

    // one table row
    // a group of rows ends at the row with drain set
    typedef struct packed {
        md_op_t op;
        word_t  a;
        word_t  b;
        logic   ext1;
        logic   ext2;
        logic   dep;
        logic   pair;
        logic   drain;
        word_t  exp;
    } row_t;

    logic                clk;
    logic                rst;
    logic [ID_WIDTH-1:0] ds_valid;
    uop_t [ID_WIDTH-1:0] ds_uop;
    logic                ds_ready;
    cdb_t                ext_cdb;
    cdb_t                cdb;

    row_t  tbl      [N_ROWS];
    logic  pending  [N_ROB];
    logic  got      [N_ROB];
    logic  wait_ext [N_ROB];
    word_t exp_val  [N_ROB];
    int    n_pending;
    int    n_results;
    int    value_errs;
    int    proto_errs;
    int    cycles;
    int    base;
    logic  saw_full;

    intm_exec #(
        .ID_WIDTH   (ID_WIDTH),
        .RS_DEPTH   (RS_DEPTH),
        .MUL_STAGES (MUL_STAGES)
    ) intm_exec_i (
        .clk      (clk),
        .rst      (rst),
        .ds_valid (ds_valid),
        .ds_uop   (ds_uop),
        .ds_ready (ds_ready),
        .ext_cdb  (ext_cdb),
        .cdb      (cdb)
    );

    always #5 clk = ~clk;

    // ----------------------------
    // M-extension reference
    // ----------------------------

    function automatic word_t md_model(md_op_t op, word_t a, word_t b);
        longint            sa;
        longint            sb;
        longint unsigned   ua;
        longint unsigned   ub;
        logic [2*XLEN-1:0] p_ss;
        logic [2*XLEN-1:0] p_su;
        logic [2*XLEN-1:0] p_uu;
        logic              ovf;
        word_t             res;
        sa   = $signed(a);
        sb   = $signed(b);
        ua   = a;
        ub   = b;
        // low 64 bits are exact for every operand mix
        p_ss = sa * sb;
        p_su = sa * ub;
        p_uu = ua * ub;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MUL:     res = p_uu[XLEN-1:0];
            MULH:    res = p_ss[2*XLEN-1:XLEN];
            MULHSU:  res = p_su[2*XLEN-1:XLEN];
            MULHU:   res = p_uu[2*XLEN-1:XLEN];
            DIV:     res = (b == '0) ? '1 : (ovf ? a : word_t'(sa / sb));
            DIVU:    res = (b == '0) ? '1 : word_t'(ua / ub);
            REM:     res = (b == '0) ? a : (ovf ? '0 : word_t'(sa % sb));
            default: res = (b == '0) ? a : word_t'(ua % ub);
        endcase
        return res;
    endfunction

    task automatic fill_table();
        row_t r;
        tbl[0]  = '{MUL,    32'h0000_0007, 32'hffff_fffd, 0, 0, 0, 1, 0, 32'hffff_ffeb};
        tbl[1]  = '{MULH,   32'h8000_0000, 32'h8000_0000, 0, 0, 0, 0, 0, 32'h4000_0000};
        tbl[2]  = '{MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0, 1, 0, 32'hffff_ffff};
        tbl[3]  = '{MULHU,  32'hffff_ffff, 32'hffff_ffff, 0, 0, 0, 0, 0, 32'hffff_fffe};
        tbl[4]  = '{DIV,    32'hffff_fff9, 32'h0000_0002, 0, 0, 0, 1, 0, 32'hffff_fffd};
        tbl[5]  = '{REM,    32'hffff_fff9, 32'h0000_0002, 0, 0, 0, 0, 0, 32'hffff_ffff};
        tbl[6]  = '{DIVU,   32'hffff_fff9, 32'h0000_0002, 0, 0, 0, 1, 0, 32'h7fff_fffc};
        tbl[7]  = '{REMU,   32'hffff_fff9, 32'h0000_0002, 0, 0, 0, 0, 0, 32'h0000_0001};
        // divide by zero
        tbl[8]  = '{DIV,    32'h0000_0005, 32'h0000_0000, 0, 0, 0, 1, 0, 32'hffff_ffff};
        tbl[9]  = '{REM,    32'h0000_0005, 32'h0000_0000, 0, 0, 0, 0, 0, 32'h0000_0005};
        tbl[10] = '{DIVU,   32'h1234_5678, 32'h0000_0000, 0, 0, 0, 1, 0, 32'hffff_ffff};
        tbl[11] = '{REMU,   32'h1234_5678, 32'h0000_0000, 0, 0, 0, 0, 0, 32'h1234_5678};
        // signed overflow
        tbl[12] = '{DIV,    32'h8000_0000, 32'hffff_ffff, 0, 0, 0, 1, 0, 32'h8000_0000};
        tbl[13] = '{REM,    32'h8000_0000, 32'hffff_ffff, 0, 0, 0, 0, 0, 32'h0000_0000};
        // sources that show up later on ext_cdb
        tbl[14] = '{MULHU,  32'h0001_0000, 32'h0003_0000, 1, 0, 0, 0, 0, 32'h0000_0003};
        tbl[15] = '{DIV,    32'h0000_0064, 32'hffff_fff9, 0, 1, 0, 0, 1, 32'hffff_fff2};
        // chains through the local cdb
        tbl[16] = '{MUL,    32'h0000_0006, 32'h0000_0007, 0, 0, 0, 1, 0, 32'h0000_002a};
        tbl[17] = '{DIVU,   32'h0000_0000, 32'h0000_0005, 0, 0, 1, 0, 0, 32'h0000_0008};
        tbl[18] = '{DIV,    32'h0000_0064, 32'h0000_0007, 0, 0, 0, 0, 0, 32'h0000_000e};
        tbl[19] = '{MUL,    32'h0000_0000, 32'hffff_fffd, 0, 0, 1, 1, 0, 32'hffff_ffd6};
        tbl[20] = '{REM,    32'h0000_0000, 32'h0000_0005, 0, 0, 1, 0, 0, 32'hffff_fffe};
        tbl[21] = '{REM,    32'h0000_0064, 32'hffff_fff9, 1, 1, 0, 0, 1, 32'h0000_0002};
        // burst of divide and multiply pairs with random operands
        for (int i = 0; i < BURST_ROWS; i++) begin
            r.op    = (i % 2 == 0) ? md_op_t'(4 + $urandom_range(3))
                                   : md_op_t'($urandom_range(3));
            r.a     = $urandom();
            r.b     = $urandom();
            r.ext1  = 1'b0;
            r.ext2  = 1'b0;
            r.dep   = 1'b0;
            r.pair  = (i % 2 == 0);
            r.drain = (i == BURST_ROWS - 1);
            r.exp   = md_model(r.op, r.a, r.b);
            tbl[DIR_ROWS + i] = r;
        end
    endtask

    // ----------------------------
    // stimulus helpers
    // ----------------------------

    // register numbers follow the row position inside its group
    function automatic uop_t build_uop(int idx);
        uop_t u;
        int   k;
        k           = idx - base;
        u.rob_id    = rob_id_t'(k);
        u.rd_phy    = phy_reg_t'(33 + k);
        u.rd_arch   = arch_reg_t'(k + 1);
        u.rs1_phy   = tbl[idx].dep ? phy_reg_t'(32 + k) : phy_reg_t'(1 + k);
        u.rs1_valid = tbl[idx].dep ? got[k-1] : !tbl[idx].ext1;
        u.rs2_phy   = phy_reg_t'(17 + k);
        u.rs2_valid = !tbl[idx].ext2;
        u.fu_opcode = tbl[idx].op;
        return u;
    endfunction

    task automatic write_ext(phy_reg_t phy, word_t value);
        ext_cdb.valid   = 1'b1;
        ext_cdb.rob_id  = '0;
        ext_cdb.rd_phy  = phy;
        ext_cdb.rd_arch = '0;
        ext_cdb.value   = value;
        @(negedge clk);
        ext_cdb = '0;
    endtask

    task automatic preload(int first, int last);
        int k;
        for (int i = first; i <= last; i++) begin
            k = i - first;
            if (!tbl[i].ext1 && !tbl[i].dep) begin
                write_ext(phy_reg_t'(1 + k), tbl[i].a);
            end
            if (!tbl[i].ext2) begin
                write_ext(phy_reg_t'(17 + k), tbl[i].b);
            end
        end
    endtask

    task automatic dispatch(int idx, int n);
        int   k;
        logic any_ext;
        any_ext = 1'b0;
        while (!ds_ready) begin
            @(negedge clk);
        end
        for (int j = 0; j < n; j++) begin
            k           = idx + j - base;
            ds_uop[j]   = build_uop(idx + j);
            ds_valid[j] = 1'b1;
            exp_val[k]  = tbl[idx + j].exp;
            pending[k]  = 1'b1;
            wait_ext[k] = tbl[idx + j].ext1 || tbl[idx + j].ext2;
            any_ext     = any_ext || wait_ext[k];
            n_pending++;
        end
        @(negedge clk);
        ds_valid = '0;
        // let the entries sit a while before their sources arrive
        if (any_ext) begin
            repeat (3) @(negedge clk);
            for (int j = 0; j < n; j++) begin
                k = idx + j - base;
                if (tbl[idx + j].ext1) begin
                    write_ext(phy_reg_t'(1 + k), tbl[idx + j].a);
                end
                if (tbl[idx + j].ext2) begin
                    write_ext(phy_reg_t'(17 + k), tbl[idx + j].b);
                end
                wait_ext[k] = 1'b0;
            end
        end
    endtask

    // ----------------------------
    // scoreboard and limits
    // ----------------------------

    always @(posedge clk) begin
        int k;
        if (!rst && cdb.valid) begin
            k = int'(cdb.rob_id);
            if (!pending[k]) begin
                $display("%0t: rob_id %0d came back on cdb with nothing outstanding", $time, k);
                proto_errs++;
            end else begin
                if (wait_ext[k]) begin
                    $display("CHECK FAILED %0t: rob_id %0d issued before its ext_cdb source",
                             $time, k);
                    value_errs++;
                end
                if (cdb.value !== exp_val[k]) begin
                    $display("CHECK FAILED %0t: rob_id %0d value %h expected %h",
                             $time, k, cdb.value, exp_val[k]);
                    value_errs++;
                end
                if (cdb.rd_phy !== phy_reg_t'(33 + k)) begin
                    $display("CHECK FAILED %0t: rob_id %0d rd_phy %0d expected %0d",
                             $time, k, cdb.rd_phy, 33 + k);
                    value_errs++;
                end
                if (cdb.rd_arch !== arch_reg_t'(k + 1)) begin
                    $display("CHECK FAILED %0t: rob_id %0d rd_arch %0d expected %0d",
                             $time, k, cdb.rd_arch, k + 1);
                    value_errs++;
                end
                pending[k] = 1'b0;
                got[k]     = 1'b1;
                n_pending--;
                n_results++;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && !ds_ready) begin
            saw_full = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles with results still outstanding", cycles);
            for (int i = 0; i < N_ROB; i++) begin
                if (pending[i]) begin
                    $display("rob_id %0d never came back on cdb", i);
                end
            end
            $display("errors: %0d value, %0d protocol, run timed out", value_errs, proto_errs);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------
    // main sequence
    // ----------------------------

    initial begin
        int idx;
        int last;
        void'($urandom(32'h35912918));
        clk        = 1'b0;
        rst        = 1'b1;
        ds_valid   = '0;
        ds_uop     = '0;
        ext_cdb    = '0;
        n_pending  = 0;
        n_results  = 0;
        value_errs = 0;
        proto_errs = 0;
        cycles     = 0;
        base       = 0;
        saw_full   = 1'b0;
        for (int i = 0; i < N_ROB; i++) begin
            pending[i]  = 1'b0;
            got[i]      = 1'b0;
            wait_ext[i] = 1'b0;
        end
        fill_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (cdb.valid !== 1'b0 || ds_ready !== 1'b1) begin
            $display("CHECK FAILED %0t: after reset cdb valid %b ds_ready %b",
                     $time, cdb.valid, ds_ready);
            value_errs++;
        end

        idx = 0;
        while (idx < N_ROWS) begin
            base = idx;
            last = idx;
            while (!tbl[last].drain) begin
                last++;
            end
            for (int i = 0; i < N_ROB; i++) begin
                got[i] = 1'b0;
            end
            preload(idx, last);
            while (idx <= last) begin
                dispatch(idx, tbl[idx].pair ? 2 : 1);
                idx += tbl[idx].pair ? 2 : 1;
            end
            while (n_pending != 0) begin
                @(negedge clk);
            end
        end

        // bus stays quiet once everything is back
        repeat (20) begin
            @(negedge clk);
            if (cdb.valid !== 1'b0) begin
                $display("CHECK FAILED %0t: cdb valid after the final result", $time);
                value_errs++;
            end
        end
        if (!saw_full) begin
            $display("ds_ready never dropped while the station was loaded");
            proto_errs++;
        end
        if (n_results != N_ROWS) begin
            $display("%0d results seen on cdb for %0d dispatched uops", n_results, N_ROWS);
            proto_errs++;
        end

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
